// File: hdl/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// character and oversampling sizes
`define UART_DATA_BITS  8
`define UART_OVERSAMPLE 16

// receive FIFO entries as a power of two
`define UART_FIFO_DEPTH 8

// baud divisor gives a tick every div+1 clocks
`define UART_DIV_BITS   16
`define UART_DIV_RESET  3

`endif

// File: hdl/uart_pkg.sv
`include "uart_cfg.svh"

package uart_pkg;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    REG_DATA   = 2'd0,
    REG_STATUS = 2'd1,
    REG_DIV    = 2'd2
  } reg_addr_t;

  // rx_empty ends up in bit 0 of the status register
  typedef struct packed {
    logic overrun;   // bit 4
    logic frame_err; // bit 3
    logic tx_busy;   // bit 2
    logic rx_full;   // bit 1
    logic rx_empty;  // bit 0
  } uart_status_t;

  typedef struct packed {
    logic [`UART_DATA_BITS-1:0] data; // received byte
    logic                       valid; // one-cycle pulse on a good stop bit
    logic                       frame_err; // one-cycle pulse on a low stop bit
  } rx_result_t;

endpackage

// File: hdl/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_baud_gen (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [`UART_DIV_BITS-1:0] i_div,
  output logic                      o_tick
);

  logic [`UART_DIV_BITS-1:0] cnt; // counts down to zero

  // reload only on wrap, so a new divisor waits for the current period
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      cnt    <= `UART_DIV_BITS'(`UART_DIV_RESET);
      o_tick <= 1'b0;
    end else begin
      if (cnt == '0) begin
        cnt    <= i_div;
        o_tick <= 1'b1; // one clock wide
      end else begin
        cnt    <= cnt - 1'b1;
        o_tick <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_tick,
  input  logic                   i_rx,
  output uart_pkg::rx_result_t   o_result
);

  localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`UART_DATA_BITS);
  localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

  uart_pkg::rx_state_t state;
  uart_pkg::rx_state_t state_nxt;

  logic                       rx_meta;   // first synchronizer flop
  logic                       rx_sync;   // safe to use
  logic                       rx_prev;   // for edge detect
  logic                       rx_fall;
  logic                       sample_now; // mid-bit of the current bit
  logic [TICK_W-1:0]          tick_cnt;
  logic [BIT_W-1:0]           bit_cnt;
  logic [`UART_DATA_BITS-1:0] shift_reg;

  assign rx_fall    = rx_prev & ~rx_sync;
  assign sample_now = i_tick &&
                      (tick_cnt == ((state == uart_pkg::RX_START) ? TICK_HALF : TICK_LAST));

  always_comb begin
    state_nxt = state;
    case (state)
      uart_pkg::RX_IDLE:  if (rx_fall) state_nxt = uart_pkg::RX_START;
      uart_pkg::RX_START: begin
        // a glitch that is high again at mid-start is ignored
        if (sample_now) state_nxt = rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
      end
      uart_pkg::RX_DATA:  if (sample_now && bit_cnt == BIT_LAST) state_nxt = uart_pkg::RX_STOP;
      uart_pkg::RX_STOP:  if (sample_now) state_nxt = uart_pkg::RX_IDLE;
      default:            state_nxt = uart_pkg::RX_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      rx_meta   <= 1'b1; // line idles high
      rx_sync   <= 1'b1;
      rx_prev   <= 1'b1;
      state     <= uart_pkg::RX_IDLE;
      tick_cnt  <= '0;
      bit_cnt   <= '0;
      shift_reg <= '0;
      o_result  <= '0;
    end else begin
      rx_meta            <= i_rx;
      rx_sync            <= rx_meta;
      rx_prev            <= rx_sync;
      state              <= state_nxt;
      o_result.valid     <= 1'b0; // pulses by default
      o_result.frame_err <= 1'b0;
      if (state == uart_pkg::RX_IDLE) begin
        tick_cnt <= '0;
        bit_cnt  <= '0;
      end else if (i_tick) begin
        tick_cnt <= sample_now ? '0 : tick_cnt + 1'b1;
      end
      if (sample_now && state == uart_pkg::RX_DATA) begin
        shift_reg <= {rx_sync, shift_reg[`UART_DATA_BITS-1:1]}; // lsb first
        bit_cnt   <= bit_cnt + 1'b1;
      end
      if (sample_now && state == uart_pkg::RX_STOP) begin
        o_result.data      <= shift_reg;
        o_result.valid     <= rx_sync;
        o_result.frame_err <= ~rx_sync; // low stop bit
      end
    end
  end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_tick,
  input  logic                       i_start,
  input  logic [`UART_DATA_BITS-1:0] i_data,
  output logic                       o_tx,
  output logic                       o_busy
);

  localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`UART_DATA_BITS);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

  uart_pkg::tx_state_t state;
  uart_pkg::tx_state_t state_nxt;

  logic [TICK_W-1:0]          tick_cnt;
  logic [BIT_W-1:0]           bit_cnt;
  logic [`UART_DATA_BITS-1:0] shift_reg;
  logic                       bit_end; // last tick of the current bit

  assign bit_end = i_tick && tick_cnt == TICK_LAST;
  assign o_busy  = (state != uart_pkg::TX_IDLE);

  always_comb begin
    state_nxt = state;
    o_tx      = 1'b1;
    case (state)
      uart_pkg::TX_IDLE: if (i_start) state_nxt = uart_pkg::TX_START;
      uart_pkg::TX_START: begin
        o_tx = 1'b0;
        if (bit_end) state_nxt = uart_pkg::TX_DATA;
      end
      uart_pkg::TX_DATA: begin
        o_tx = shift_reg[0];
        if (bit_end && bit_cnt == BIT_LAST) state_nxt = uart_pkg::TX_STOP;
      end
      uart_pkg::TX_STOP: if (bit_end) state_nxt = uart_pkg::TX_IDLE;
      default:           state_nxt = uart_pkg::TX_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state     <= uart_pkg::TX_IDLE;
      tick_cnt  <= '0;
      bit_cnt   <= '0;
      shift_reg <= '0;
    end else begin
      state <= state_nxt;
      if (state == uart_pkg::TX_IDLE) begin
        tick_cnt <= '0;
        bit_cnt  <= '0;
        if (i_start) shift_reg <= i_data; // latch byte at start
      end else if (i_tick) begin
        tick_cnt <= tick_cnt + 1'b1; // wraps every 16 ticks
      end
      if (bit_end && state == uart_pkg::TX_DATA) begin
        shift_reg <= shift_reg >> 1;
        bit_cnt   <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// File: hdl/uart_rx_fifo.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_fifo (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_push,
  input  logic [`UART_DATA_BITS-1:0] i_push_data,
  input  logic                       i_pop,
  output logic [`UART_DATA_BITS-1:0] o_head,
  output logic                       o_empty,
  output logic                       o_full,
  output logic                       o_overflow
);

  localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

  logic [`UART_DATA_BITS-1:0] mem [`UART_FIFO_DEPTH];
  logic [PTR_W-1:0]           wr_ptr; // wraps since depth is a power of two
  logic [PTR_W-1:0]           rd_ptr;
  logic [PTR_W:0]             count;
  logic                       push_ok;
  logic                       pop_ok;

  assign o_empty = (count == '0);
  assign o_full  = (count == (PTR_W+1)'(`UART_FIFO_DEPTH));
  assign o_head  = mem[rd_ptr];
  assign push_ok = i_push & ~o_full; // stored bytes are never overwritten
  assign pop_ok  = i_pop & ~o_empty;

  always_ff @(posedge i_clk) begin
    if (push_ok) mem[wr_ptr] <= i_push_data;
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      o_overflow <= i_push & o_full;
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/uart_wb_regs.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_wb_regs (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_wb_cyc,
  input  logic                       i_wb_stb,
  input  logic                       i_wb_we,
  input  logic [1:0]                 i_wb_adr,
  input  logic [`UART_DATA_BITS-1:0] i_wb_dat,
  output logic [`UART_DATA_BITS-1:0] o_wb_dat,
  output logic                       o_wb_ack,
  input  logic                       i_frame_err,
  input  logic                       i_overflow,
  input  logic [`UART_DATA_BITS-1:0] i_fifo_head,
  input  logic                       i_fifo_empty,
  input  logic                       i_fifo_full,
  input  logic                       i_tx_busy,
  output logic                       o_pop,
  output logic                       o_tx_start,
  output logic [`UART_DATA_BITS-1:0] o_tx_data,
  output logic [`UART_DIV_BITS-1:0]  o_div
);

  uart_pkg::uart_status_t status;
  uart_pkg::reg_addr_t    addr;

  logic req;       // new request, ack not yet given
  logic frame_err_q; // sticky until status read
  logic overrun_q;

  assign req  = i_wb_cyc & i_wb_stb & ~o_wb_ack;
  assign addr = uart_pkg::reg_addr_t'(i_wb_adr);

  assign status.rx_empty  = i_fifo_empty;
  assign status.rx_full   = i_fifo_full;
  assign status.tx_busy   = i_tx_busy;
  assign status.frame_err = frame_err_q;
  assign status.overrun   = overrun_q;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_wb_ack    <= 1'b0;
      o_wb_dat    <= '0;
      o_pop       <= 1'b0;
      o_tx_start  <= 1'b0;
      o_tx_data   <= '0;
      o_div       <= `UART_DIV_BITS'(`UART_DIV_RESET);
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
    end else begin
      o_wb_ack   <= req; // exactly one cycle
      o_pop      <= 1'b0;
      o_tx_start <= 1'b0;
      if (req && !i_wb_we) begin
        case (addr)
          uart_pkg::REG_DATA: begin
            o_wb_dat <= i_fifo_empty ? '0 : i_fifo_head;
            o_pop    <= ~i_fifo_empty; // pops as the ack goes out
          end
          uart_pkg::REG_STATUS: o_wb_dat <= `UART_DATA_BITS'(status);
          uart_pkg::REG_DIV:    o_wb_dat <= o_div[`UART_DATA_BITS-1:0];
          default:              o_wb_dat <= '0;
        endcase
      end
      if (req && i_wb_we) begin
        case (addr)
          uart_pkg::REG_DATA: begin
            o_tx_start <= ~i_tx_busy; // dropped while busy
            if (!i_tx_busy) o_tx_data <= i_wb_dat;
          end
          uart_pkg::REG_DIV: o_div <= `UART_DIV_BITS'(i_wb_dat);
          default: ;
        endcase
      end
      // status read clears, but a new error in the same cycle wins
      if (req && !i_wb_we && addr == uart_pkg::REG_STATUS) begin
        frame_err_q <= i_frame_err;
        overrun_q   <= i_overflow;
      end else begin
        frame_err_q <= frame_err_q | i_frame_err;
        overrun_q   <= overrun_q | i_overflow;
      end
    end
  end

endmodule

// File: hdl/uart_top.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_top (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_wb_cyc,
  input  logic                       i_wb_stb,
  input  logic                       i_wb_we,
  input  logic [1:0]                 i_wb_adr,
  input  logic [`UART_DATA_BITS-1:0] i_wb_dat,
  output logic [`UART_DATA_BITS-1:0] o_wb_dat,
  output logic                       o_wb_ack,
  input  logic                       i_rx,
  output logic                       o_tx
);

  uart_pkg::rx_result_t       rx_result;
  logic                       tick;
  logic [`UART_DIV_BITS-1:0]  div;
  logic [`UART_DATA_BITS-1:0] fifo_head;
  logic                       fifo_empty;
  logic                       fifo_full;
  logic                       fifo_overflow;
  logic                       pop;
  logic                       tx_start;
  logic [`UART_DATA_BITS-1:0] tx_data;
  logic                       tx_busy;

  uart_baud_gen u_baud (.i_clk(i_clk), .i_rst(i_rst), .i_div(div), .o_tick(tick));

  uart_rx u_rx (.i_clk(i_clk), .i_rst(i_rst), .i_tick(tick), .i_rx(i_rx), .o_result(rx_result));

  uart_rx_fifo u_fifo (
    .i_clk(i_clk), .i_rst(i_rst), .i_push(rx_result.valid), .i_push_data(rx_result.data),
    .i_pop(pop), .o_head(fifo_head), .o_empty(fifo_empty), .o_full(fifo_full),
    .o_overflow(fifo_overflow)
  );

  uart_tx u_tx (
    .i_clk(i_clk), .i_rst(i_rst), .i_tick(tick), .i_start(tx_start), .i_data(tx_data),
    .o_tx(o_tx), .o_busy(tx_busy)
  );

  uart_wb_regs u_regs (
    .i_clk(i_clk), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
    .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat),
    .o_wb_ack(o_wb_ack), .i_frame_err(rx_result.frame_err), .i_overflow(fifo_overflow),
    .i_fifo_head(fifo_head), .i_fifo_empty(fifo_empty), .i_fifo_full(fifo_full),
    .i_tx_busy(tx_busy), .o_pop(pop), .o_tx_start(tx_start), .o_tx_data(tx_data),
    .o_div(div)
  );

endmodule

// File: dv/uart_tb.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tb;

  localparam int CLK_NS     = 20;
  localparam int RST_CYCLES = 16;
  localparam int N_LOOP     = 4;
  // 15 frames of 640 clocks at divisor 3, one of 1280 at divisor 7, plus bus polling
  localparam int MAX_CYCLES = 60000;

  logic       i_clk;
  logic       i_rst;
  logic       i_wb_cyc;
  logic       i_wb_stb;
  logic       i_wb_we;
  logic [1:0] i_wb_adr;
  logic [7:0] i_wb_dat;
  logic [7:0] o_wb_dat;
  logic       o_wb_ack;
  logic       i_rx;
  logic       o_tx;

  logic       loopback; // o_tx feeds i_rx
  logic       drv_rx;   // serial driver line
  integer     seed;
  integer     cycles;
  integer     period;
  integer     i;
  logic [7:0] rd_val;
  logic [7:0] tx_byte;
  logic [7:0] expected [$];

  assign i_rx = loopback ? o_tx : drv_rx;

  uart_top uut (
    .i_clk(i_clk), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
    .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat),
    .o_wb_ack(o_wb_ack), .i_rx(i_rx), .o_tx(o_tx)
  );

  always #(CLK_NS / 2) i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input integer got, input integer exp);
    assert (got == exp) else begin
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // status layout: overrun, frame_err, tx_busy, rx_full, rx_empty from bit 4 down
  function automatic logic [7:0] status_word(input logic empty, input logic full,
                                             input logic busy, input logic ferr,
                                             input logic ovr);
    return {3'b000, ovr, ferr, busy, full, empty};
  endfunction

  function automatic integer bit_clocks(input integer div);
    return `UART_OVERSAMPLE * (div + 1);
  endfunction

  // one Wishbone classic cycle, held until ack
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    @(posedge i_clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_dat <= wdat;
    @(negedge i_clk);
    while (o_wb_ack !== 1'b1) @(negedge i_clk);
    rdat = o_wb_dat; // valid with ack
    @(posedge i_clk);
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
    @(negedge i_clk);
    check_value("o_wb_ack", o_wb_ack, 0); // ack is one cycle wide
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [7:0] wdat);
    logic [7:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic bus_read(input logic [1:0] adr, output logic [7:0] rdat);
    bus_cycle(1'b0, adr, 8'h00, rdat);
  endtask

  task automatic wait_tx_idle();
    logic [7:0] d;
    do begin
      bus_read(uart_pkg::REG_STATUS, d);
      check_value("status.frame_err", d[3], 0);
    end while (d[2]); // tx_busy
  endtask

  task automatic wait_rx_ready();
    logic [7:0] d;
    do begin
      bus_read(uart_pkg::REG_STATUS, d);
    end while (d[0]); // rx_empty
  endtask

  // start bit, data lsb first, chosen stop bit, then one idle bit
  task automatic send_frame(input logic [7:0] data, input logic stop_bit, input integer div);
    logic [9:0] frame;
    integer     b;
    frame = {stop_bit, data, 1'b0};
    for (b = 0; b < 10; b++) begin
      @(posedge i_clk);
      drv_rx <= frame[b];
      repeat (bit_clocks(div) - 1) @(posedge i_clk);
    end
    @(posedge i_clk);
    drv_rx <= 1'b1;
    repeat (bit_clocks(div)) @(posedge i_clk);
  endtask

  task automatic capture_tx_byte(input integer div, output logic [7:0] data);
    integer b;
    @(negedge o_tx);
    repeat (bit_clocks(div) / 2) @(negedge i_clk); // center of start bit
    check_value("o_tx start bit", o_tx, 0);
    for (b = 0; b < 8; b++) begin
      repeat (bit_clocks(div)) @(negedge i_clk);
      data[b] = o_tx;
    end
    repeat (bit_clocks(div)) @(negedge i_clk);
    check_value("o_tx stop bit", o_tx, 1);
  endtask

  // bit 0 high and bit 1 low, so rise to next fall is one data bit
  task automatic measure_bit_period(output integer clocks);
    longint t_rise;
    @(negedge o_tx);
    @(posedge o_tx);
    t_rise = $time;
    @(negedge o_tx);
    clocks = int'(($time - t_rise) / CLK_NS);
  endtask

  initial begin
    seed     = 86;
    cycles   = 0;
    i_clk    = 1'b0;
    i_rst    = 1'b1;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = 2'd0;
    i_wb_dat = 8'h00;
    loopback = 1'b0;
    drv_rx   = 1'b1;
    repeat (RST_CYCLES) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);

    // reset state
    check_value("o_tx", o_tx, 1);
    check_value("o_wb_ack", o_wb_ack, 0);
    bus_read(uart_pkg::REG_STATUS, rd_val);
    check_value("status", rd_val, status_word(1, 0, 0, 0, 0));
    bus_read(uart_pkg::REG_DIV, rd_val);
    check_value("divisor", rd_val, `UART_DIV_RESET);

    // transmit framing with the receiver held idle
    tx_byte = 8'($random(seed));
    fork
      capture_tx_byte(`UART_DIV_RESET, rd_val);
      bus_write(uart_pkg::REG_DATA, tx_byte);
    join
    check_value("o_tx data bits", rd_val, tx_byte);
    wait_tx_idle();

    // loopback receive
    @(posedge i_clk);
    loopback <= 1'b1;
    for (i = 0; i < N_LOOP; i++) begin
      tx_byte = 8'($random(seed));
      expected.push_back(tx_byte);
      bus_write(uart_pkg::REG_DATA, tx_byte);
      wait_tx_idle();
    end
    for (i = 0; i < N_LOOP; i++) begin
      bus_read(uart_pkg::REG_DATA, rd_val);
      check_value("rx data", rd_val, expected.pop_front());
    end
    bus_read(uart_pkg::REG_STATUS, rd_val);
    check_value("status", rd_val, status_word(1, 0, 0, 0, 0));

    // framing error
    @(posedge i_clk);
    loopback <= 1'b0;
    tx_byte = 8'($random(seed));
    send_frame(tx_byte, 1'b0, `UART_DIV_RESET);
    bus_read(uart_pkg::REG_STATUS, rd_val);
    check_value("status", rd_val, status_word(1, 0, 0, 1, 0));
    bus_read(uart_pkg::REG_STATUS, rd_val);
    check_value("status", rd_val, status_word(1, 0, 0, 0, 0));

    // overrun, one frame more than the FIFO holds
    for (i = 0; i <= `UART_FIFO_DEPTH; i++) begin
      tx_byte = 8'($random(seed));
      if (i < `UART_FIFO_DEPTH) expected.push_back(tx_byte);
      send_frame(tx_byte, 1'b1, `UART_DIV_RESET);
    end
    bus_read(uart_pkg::REG_STATUS, rd_val);
    check_value("status", rd_val, status_word(0, 1, 0, 0, 1));
    for (i = 0; i < `UART_FIFO_DEPTH; i++) begin
      bus_read(uart_pkg::REG_DATA, rd_val);
      check_value("rx data", rd_val, expected.pop_front());
    end
    bus_read(uart_pkg::REG_STATUS, rd_val);
    check_value("status", rd_val, status_word(1, 0, 0, 0, 0));

    // divisor change
    bus_write(uart_pkg::REG_DIV, 8'd7);
    bus_read(uart_pkg::REG_DIV, rd_val);
    check_value("divisor", rd_val, 7);
    @(posedge i_clk);
    loopback <= 1'b1;
    tx_byte = (8'($random(seed)) & 8'hfc) | 8'h01;
    fork
      measure_bit_period(period);
      bus_write(uart_pkg::REG_DATA, tx_byte);
    join
    wait_rx_ready();
    bus_read(uart_pkg::REG_DATA, rd_val);
    check_value("rx data", rd_val, tx_byte);
    assert (period >= bit_clocks(7) - 8 && period <= bit_clocks(7) + 8) else begin
      $display("Error at %0d ns: o_tx bit period is %0d clocks, expected %0d", $time,
               period, bit_clocks(7));
      $display("SIMULATION FAILED");
      $fatal(1);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_rx_fifo.sv
hdl/uart_wb_regs.sv
hdl/uart_top.sv
dv/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module uart_tb \
  -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/Vuart_tb > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
  echo "failure reported in $SIM_LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "run finished cleanly"
exit 0
